/* hdl/sched_defs.svh */
// Scheduler configuration constants
`ifndef SCHED_DEFS_SVH
`define SCHED_DEFS_SVH

// Sizes of the system
`define SCHED_IF_COUNT       3
`define SCHED_CORE_COUNT     16
`define SCHED_SLOT_COUNT     16
`define SCHED_SLOT_WIDTH     5
`define SCHED_CORE_WIDTH     4
`define SCHED_PORT_WIDTH     2
`define SCHED_LINE_WIDTH     13
`define SCHED_HASH_OFFSET    0

// Reset and idle values
`define SCHED_DROP_LIMIT_RST 13'd3584
`define SCHED_RD_INVALID     32'hFEFE_FEFE

// Host register numbers for the core view and then the interface view
`define SCHED_REG_INCOME     4'd1
`define SCHED_REG_FLUSH      4'd2
`define SCHED_REG_SLOTS      4'd3
`define SCHED_REG_DROPS      4'd2
`define SCHED_REG_LIMIT      4'd3

`endif

/* hdl/sched_pkg.sv */
// Scheduler shared types
`include "sched_defs.svh"

package sched_pkg;

  // Flow hash offered by one interface
  typedef struct packed {
    logic [31:0] hash;
  } hash_req_t;

  // Free slot handed back by a core
  typedef struct packed {
    logic [`SCHED_CORE_WIDTH-1:0] core;
    logic [`SCHED_SLOT_WIDTH-1:0] slot;
  } slot_ret_t;

  // Receive descriptor with slot zero on a drop
  typedef struct packed {
    logic                         drop;
    logic [`SCHED_PORT_WIDTH-1:0] port;
    logic [`SCHED_CORE_WIDTH-1:0] core;
    logic [`SCHED_SLOT_WIDTH-1:0] slot;
    logic [31:0]                  hash;
  } rx_desc_t;

  // Host command aimed at a core register
  typedef struct packed {
    logic                         wr;
    logic                         to_if;
    logic                         sched;
    logic [24-`SCHED_CORE_WIDTH:0] rsvd;
    logic [`SCHED_CORE_WIDTH-1:0] core;
    logic [3:0]                   regnum;
  } core_cmd_t;

  // Host command aimed at an interface register
  typedef struct packed {
    logic                         wr;
    logic                         to_if;
    logic                         sched;
    logic [24-`SCHED_PORT_WIDTH:0] rsvd;
    logic [`SCHED_PORT_WIDTH-1:0] port;
    logic [3:0]                   regnum;
  } port_cmd_t;

  // Bit 30 picks which view applies
  typedef union packed {
    core_cmd_t core_cmd;
    port_cmd_t port_cmd;
  } host_cmd_u;

endpackage

/* hdl/port_arbiter.sv */
// Round-robin port arbiter
`timescale 1ns/1ns
`include "sched_defs.svh"

module port_arbiter
  import sched_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst_r,
  input  hash_req_t [`SCHED_IF_COUNT-1:0]  hash_req,
  input  logic [`SCHED_IF_COUNT-1:0]       hash_valid,
  output logic [`SCHED_IF_COUNT-1:0]       hash_ready,
  output logic                             grant_valid,
  output logic [`SCHED_PORT_WIDTH-1:0]     grant_port,
  output logic [`SCHED_CORE_WIDTH-1:0]     grant_core,
  output hash_req_t                        grant_hash,
  input  logic                             grant_take
);

  localparam int IF_COUNT = `SCHED_IF_COUNT;
  localparam int PW = `SCHED_PORT_WIDTH;

  logic [IF_COUNT-1:0] last_mask;
  logic [IF_COUNT-1:0] req;
  logic [PW-1:0]       last_port;
  logic                win_valid;
  logic [PW-1:0]       win_port;

  // The port granted last cycle is still waiting on its take
  always_comb begin
    last_mask = '0;
    if (grant_valid) begin
      last_mask[grant_port] = 1'b1;
    end
  end

  assign req = hash_valid & ~last_mask;

  // Search starts just after the last winner
  always_comb begin
    int idx;
    win_valid = 1'b0;
    win_port  = '0;
    for (int k = 1; k <= IF_COUNT; k++) begin
      idx = (int'(last_port) + k) % IF_COUNT;
      if (!win_valid && req[idx]) begin
        win_valid = 1'b1;
        win_port  = PW'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      grant_valid <= 1'b0;
      last_port   <= PW'(IF_COUNT - 1);
    end else begin
      grant_valid <= win_valid;
      if (win_valid) begin
        last_port <= win_port;
      end
    end
  end

  // Destination core comes from the low hash bits
  always_ff @(posedge clk) begin
    grant_port <= win_port;
    grant_hash <= hash_req[win_port];
    grant_core <= hash_req[win_port].hash[`SCHED_HASH_OFFSET +: `SCHED_CORE_WIDTH];
  end

  // Hash is consumed only when the allocator takes the grant
  always_comb begin
    for (int p = 0; p < IF_COUNT; p++) begin
      hash_ready[p] = grant_valid && grant_take && (grant_port == PW'(p));
    end
  end

endmodule

/* hdl/slot_pool.sv */
// Per-core free slot pools
`timescale 1ns/1ns
`include "sched_defs.svh"

module slot_pool
  import sched_pkg::*;
(
  input  logic                                               clk,
  input  logic                                               rst_r,
  input  slot_ret_t                                          slot_ret,
  input  logic                                               slot_valid,
  output logic                                               slot_ready,
  input  logic [`SCHED_CORE_COUNT-1:0]                       flush_mask,
  input  logic [`SCHED_CORE_WIDTH-1:0]                       pop_core,
  input  logic                                               pop_valid,
  output logic [`SCHED_CORE_COUNT-1:0]                       slot_avail,
  output logic [`SCHED_CORE_COUNT-1:0][`SCHED_SLOT_WIDTH-1:0] slot_head,
  output logic [`SCHED_CORE_COUNT-1:0][`SCHED_SLOT_WIDTH-1:0] slot_count
);

  localparam int CORE_COUNT = `SCHED_CORE_COUNT;
  localparam int SLOT_COUNT = `SCHED_SLOT_COUNT;
  localparam int SW = `SCHED_SLOT_WIDTH;
  localparam int CW = `SCHED_CORE_WIDTH;
  localparam int PTR_W = $clog2(SLOT_COUNT);

  logic [CORE_COUNT-1:0] pool_full;

  // Returns stall only when the named pool is full
  assign slot_ready = !pool_full[slot_ret.core];

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_pool
    logic [SW-1:0]    mem [SLOT_COUNT];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [SW-1:0]    count;
    logic             push;
    logic             pop;

    assign push = slot_valid && slot_ready && (slot_ret.core == CW'(c));
    assign pop  = pop_valid && (pop_core == CW'(c));

    // Flush wins over a push or pop in the same cycle
    always_ff @(posedge clk) begin
      if (rst_r || flush_mask[c]) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end else begin
        if (push) begin
          wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
        case ({push, pop})
          2'b10:   count <= count + 1'b1;
          2'b01:   count <= count - 1'b1;
          default: count <= count;
        endcase
      end
    end

    always_ff @(posedge clk) begin
      if (push) begin
        mem[wr_ptr] <= slot_ret.slot;
      end
    end

    // Head is read straight from storage, so a pushed slot shows next cycle
    assign pool_full[c]  = (count == SW'(SLOT_COUNT));
    assign slot_avail[c] = (count != '0);
    assign slot_head[c]  = mem[rd_ptr];
    assign slot_count[c] = count;
  end

endmodule

/* hdl/desc_allocator.sv */
// Descriptor allocator
`timescale 1ns/1ns
`include "sched_defs.svh"

module desc_allocator
  import sched_pkg::*;
(
  input  logic                                               clk,
  input  logic                                               rst_r,
  input  logic                                               grant_valid,
  input  logic [`SCHED_PORT_WIDTH-1:0]                       grant_port,
  input  logic [`SCHED_CORE_WIDTH-1:0]                       grant_core,
  input  hash_req_t                                          grant_hash,
  output logic                                               grant_take,
  input  logic [`SCHED_CORE_COUNT-1:0]                       slot_avail,
  input  logic [`SCHED_CORE_COUNT-1:0][`SCHED_SLOT_WIDTH-1:0] slot_head,
  output logic [`SCHED_CORE_WIDTH-1:0]                       pop_core,
  output logic                                               pop_valid,
  input  logic [`SCHED_CORE_COUNT-1:0]                       income_mask,
  input  logic [`SCHED_IF_COUNT-1:0]                         almost_full,
  output rx_desc_t                                           desc,
  output logic                                               desc_valid,
  input  logic                                               desc_ready,
  output logic [`SCHED_IF_COUNT-1:0][31:0]                   drop_count
);

  localparam int IF_COUNT = `SCHED_IF_COUNT;
  localparam int PW = `SCHED_PORT_WIDTH;

  logic     out_free;
  logic     can_alloc;
  logic     can_drop;
  logic     take_drop;
  rx_desc_t next_desc;

  // A held descriptor blocks every take
  assign out_free = !desc_valid || desc_ready;

  // Core must accept traffic and have a free slot
  assign can_alloc = income_mask[grant_core] && slot_avail[grant_core];

  // Without a slot the packet is dropped only if its buffer is nearly full
  assign can_drop = almost_full[grant_port];

  assign grant_take = grant_valid && out_free && (can_alloc || can_drop);
  assign take_drop  = grant_take && !can_alloc;
  assign pop_valid  = grant_take && can_alloc;
  assign pop_core   = grant_core;

  always_comb begin
    next_desc.drop = !can_alloc;
    next_desc.port = grant_port;
    next_desc.core = grant_core;
    next_desc.slot = can_alloc ? slot_head[grant_core] : '0;
    next_desc.hash = grant_hash.hash;
  end

  // One-entry output register
  always_ff @(posedge clk) begin
    if (rst_r) begin
      desc_valid <= 1'b0;
    end else if (grant_take) begin
      desc_valid <= 1'b1;
    end else if (desc_ready) begin
      desc_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (grant_take) begin
      desc <= next_desc;
    end
  end

  // Drops counted per receiving interface
  always_ff @(posedge clk) begin
    if (rst_r) begin
      drop_count <= '0;
    end else begin
      for (int p = 0; p < IF_COUNT; p++) begin
        if (take_drop && (grant_port == PW'(p))) begin
          drop_count[p] <= drop_count[p] + 32'd1;
        end
      end
    end
  end

endmodule

/* hdl/host_regs.sv */
// Host command registers
`timescale 1ns/1ns
`include "sched_defs.svh"

module host_regs
  import sched_pkg::*;
(
  input  logic                                               clk,
  input  logic                                               rst_r,
  input  host_cmd_u                                          host_cmd,
  input  logic [31:0]                                        host_wr_data,
  input  logic                                               host_valid,
  output logic [31:0]                                        host_rd_data,
  input  logic [`SCHED_IF_COUNT-1:0][`SCHED_LINE_WIDTH-1:0]   line_count,
  input  logic [`SCHED_CORE_COUNT-1:0][`SCHED_SLOT_WIDTH-1:0] slot_count,
  input  logic [`SCHED_IF_COUNT-1:0][31:0]                   drop_count,
  output logic [`SCHED_CORE_COUNT-1:0]                       income_mask,
  output logic [`SCHED_CORE_COUNT-1:0]                       flush_mask,
  output logic [`SCHED_IF_COUNT-1:0]                         almost_full
);

  localparam int IF_COUNT = `SCHED_IF_COUNT;
  localparam int CORE_COUNT = `SCHED_CORE_COUNT;
  localparam int LW = `SCHED_LINE_WIDTH;
  localparam int PW = `SCHED_PORT_WIDTH;

  host_cmd_u                    cmd_r;
  logic [31:0]                  wr_data_r;
  logic                         wr_en_r;
  logic [IF_COUNT-1:0][LW-1:0]  line_count_r;
  logic [LW-1:0]                drop_limit;
  logic                         core_wr;
  logic                         port_wr;
  logic [31:0]                  rd_next;

  always_ff @(posedge clk) begin
    cmd_r        <= host_cmd;
    wr_data_r    <= host_wr_data;
    line_count_r <= line_count;
    host_rd_data <= rd_next;
  end

  // Flag bits sit at the same place in both views
  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_en_r <= 1'b0;
    end else begin
      wr_en_r <= host_valid && host_cmd.core_cmd.wr && host_cmd.core_cmd.sched;
    end
  end

  assign core_wr = wr_en_r && !cmd_r.core_cmd.to_if;
  assign port_wr = wr_en_r && cmd_r.port_cmd.to_if;

  // Flush is a single-cycle pulse
  always_ff @(posedge clk) begin
    if (rst_r) begin
      income_mask <= '0;
      flush_mask  <= '0;
      drop_limit  <= `SCHED_DROP_LIMIT_RST;
    end else begin
      flush_mask <= '0;
      if (core_wr && cmd_r.core_cmd.regnum == `SCHED_REG_INCOME) begin
        income_mask <= wr_data_r[CORE_COUNT-1:0];
      end
      if (core_wr && cmd_r.core_cmd.regnum == `SCHED_REG_FLUSH) begin
        flush_mask <= wr_data_r[CORE_COUNT-1:0];
      end
      if (port_wr && cmd_r.port_cmd.regnum == `SCHED_REG_LIMIT) begin
        drop_limit <= wr_data_r[LW-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      almost_full <= '0;
    end else begin
      for (int p = 0; p < IF_COUNT; p++) begin
        almost_full[p] <= (line_count_r[p] >= drop_limit);
      end
    end
  end

  // Readback through the view chosen by the interface flag
  always_comb begin
    rd_next = `SCHED_RD_INVALID;
    if (!cmd_r.core_cmd.to_if) begin
      case (cmd_r.core_cmd.regnum)
        `SCHED_REG_INCOME: rd_next = 32'(income_mask);
        `SCHED_REG_SLOTS:  rd_next = 32'(slot_count[cmd_r.core_cmd.core]);
        default:           rd_next = `SCHED_RD_INVALID;
      endcase
    end else if (cmd_r.port_cmd.port < PW'(IF_COUNT)) begin
      case (cmd_r.port_cmd.regnum)
        `SCHED_REG_DROPS: rd_next = drop_count[cmd_r.port_cmd.port];
        `SCHED_REG_LIMIT: rd_next = 32'(drop_limit);
        default:          rd_next = `SCHED_RD_INVALID;
      endcase
    end
  end

endmodule

/* hdl/rx_scheduler.sv */
// Receive descriptor scheduler
`timescale 1ns/1ns
`include "sched_defs.svh"

module rx_scheduler
  import sched_pkg::*;
(
  input  logic                                             clk,
  input  logic                                             rst_r,
  input  hash_req_t [`SCHED_IF_COUNT-1:0]                  hash_req,
  input  logic [`SCHED_IF_COUNT-1:0]                       hash_valid,
  output logic [`SCHED_IF_COUNT-1:0]                       hash_ready,
  input  logic [`SCHED_IF_COUNT-1:0][`SCHED_LINE_WIDTH-1:0] line_count,
  input  slot_ret_t                                        slot_ret,
  input  logic                                             slot_valid,
  output logic                                             slot_ready,
  output rx_desc_t                                         desc,
  output logic                                             desc_valid,
  input  logic                                             desc_ready,
  input  host_cmd_u                                        host_cmd,
  input  logic [31:0]                                      host_wr_data,
  input  logic                                             host_valid,
  output logic [31:0]                                      host_rd_data
);

  // Grant path
  logic                                               grant_valid;
  logic [`SCHED_PORT_WIDTH-1:0]                       grant_port;
  logic [`SCHED_CORE_WIDTH-1:0]                       grant_core;
  hash_req_t                                          grant_hash;
  logic                                               grant_take;

  // Pool state and pops
  logic [`SCHED_CORE_COUNT-1:0]                       slot_avail;
  logic [`SCHED_CORE_COUNT-1:0][`SCHED_SLOT_WIDTH-1:0] slot_head;
  logic [`SCHED_CORE_COUNT-1:0][`SCHED_SLOT_WIDTH-1:0] slot_count;
  logic [`SCHED_CORE_WIDTH-1:0]                       pop_core;
  logic                                               pop_valid;

  // Host controls and status
  logic [`SCHED_CORE_COUNT-1:0]                       income_mask;
  logic [`SCHED_CORE_COUNT-1:0]                       flush_mask;
  logic [`SCHED_IF_COUNT-1:0]                         almost_full;
  logic [`SCHED_IF_COUNT-1:0][31:0]                   drop_count;

  port_arbiter u_port_arbiter (
    .clk         (clk),
    .rst_r       (rst_r),
    .hash_req    (hash_req),
    .hash_valid  (hash_valid),
    .hash_ready  (hash_ready),
    .grant_valid (grant_valid),
    .grant_port  (grant_port),
    .grant_core  (grant_core),
    .grant_hash  (grant_hash),
    .grant_take  (grant_take)
  );

  slot_pool u_slot_pool (
    .clk        (clk),
    .rst_r      (rst_r),
    .slot_ret   (slot_ret),
    .slot_valid (slot_valid),
    .slot_ready (slot_ready),
    .flush_mask (flush_mask),
    .pop_core   (pop_core),
    .pop_valid  (pop_valid),
    .slot_avail (slot_avail),
    .slot_head  (slot_head),
    .slot_count (slot_count)
  );

  desc_allocator u_desc_allocator (
    .clk         (clk),
    .rst_r       (rst_r),
    .grant_valid (grant_valid),
    .grant_port  (grant_port),
    .grant_core  (grant_core),
    .grant_hash  (grant_hash),
    .grant_take  (grant_take),
    .slot_avail  (slot_avail),
    .slot_head   (slot_head),
    .pop_core    (pop_core),
    .pop_valid   (pop_valid),
    .income_mask (income_mask),
    .almost_full (almost_full),
    .desc        (desc),
    .desc_valid  (desc_valid),
    .desc_ready  (desc_ready),
    .drop_count  (drop_count)
  );

  host_regs u_host_regs (
    .clk          (clk),
    .rst_r        (rst_r),
    .host_cmd     (host_cmd),
    .host_wr_data (host_wr_data),
    .host_valid   (host_valid),
    .host_rd_data (host_rd_data),
    .line_count   (line_count),
    .slot_count   (slot_count),
    .drop_count   (drop_count),
    .income_mask  (income_mask),
    .flush_mask   (flush_mask),
    .almost_full  (almost_full)
  );

endmodule

/* sim/rx_scheduler_assert.sv */
// Scheduler protocol assertions
`timescale 1ns/1ns
`include "sched_defs.svh"

module rx_scheduler_assert
  import sched_pkg::*;
(
  input logic                       clk,
  input logic                       rst_r,
  input rx_desc_t                   desc,
  input logic                       desc_valid,
  input logic                       desc_ready,
  input logic [`SCHED_IF_COUNT-1:0] hash_valid,
  input logic [`SCHED_IF_COUNT-1:0] hash_ready
);

  int assert_errors = 0;

  // A stalled descriptor stays put
  desc_hold: assert property (@(posedge clk) disable iff (rst_r)
    desc_valid && !desc_ready |=> desc_valid && $stable(desc))
    else begin
      $error("descriptor changed or vanished while stalled");
      assert_errors++;
    end

  reset_idle: assert property (@(posedge clk) $past(rst_r) |-> !desc_valid)
    else begin
      $error("descriptor valid during reset");
      assert_errors++;
    end

  // Slot numbers start at one, so only a drop carries slot zero
  drop_slot: assert property (@(posedge clk) disable iff (rst_r)
    desc_valid |-> (desc.drop == (desc.slot == '0)))
    else begin
      $error("descriptor slot does not match its drop flag");
      assert_errors++;
    end

  // Only the granted port is consumed, and only while it still offers a hash
  one_ready: assert property (@(posedge clk) disable iff (rst_r)
    $onehot0(hash_ready) && ((hash_ready & ~hash_valid) == '0))
    else begin
      $error("hash ready without a single pending request");
      assert_errors++;
    end

endmodule

bind rx_scheduler rx_scheduler_assert u_rx_scheduler_assert (
  .clk        (clk),
  .rst_r      (rst_r),
  .desc       (desc),
  .desc_valid (desc_valid),
  .desc_ready (desc_ready),
  .hash_valid (hash_valid),
  .hash_ready (hash_ready)
);

/* sim/rx_scheduler_tb.sv */
// Receive scheduler testbench
`timescale 1ns/1ns
`include "sched_defs.svh"

module rx_scheduler_tb
  import sched_pkg::*;
();

  localparam int IF_COUNT = `SCHED_IF_COUNT;

  typedef enum logic [2:0] {
    OP_RCORE, OP_RPORT, OP_WCORE, OP_RET, OP_LINES, OP_REQ, OP_QUIET, OP_DRAIN
  } op_t;

  typedef struct packed {
    logic [2:0]                   test;
    op_t                          op;
    logic [3:0]                   idx;
    logic [3:0]                   regnum;
    logic [31:0]                  value;
    logic [`SCHED_SLOT_WIDTH-1:0] slot;
    logic                         drop;
    logic                         stall;
  } step_t;

  localparam int STEP_COUNT = 40;
  localparam int CYCLE_LIMIT = STEP_COUNT * 200;

  // test, op, core or port, register or expected core, data or hash or lines, slot, drop, stall
  localparam step_t STEPS [STEP_COUNT] = '{
    '{3'd1, OP_RCORE, 4'd0, `SCHED_REG_INCOME, 32'h0000_0000, 5'd0, 1'b0, 1'b0},
    '{3'd1, OP_RPORT, 4'd0, `SCHED_REG_LIMIT, 32'd3584, 5'd0, 1'b0, 1'b0},
    '{3'd1, OP_RCORE, 4'd0, 4'd15, 32'hFEFE_FEFE, 5'd0, 1'b0, 1'b0},
    '{3'd2, OP_RET, 4'd6, 4'd0, 32'h0, 5'd5, 1'b0, 1'b0},
    '{3'd2, OP_RET, 4'd6, 4'd0, 32'h0, 5'd9, 1'b0, 1'b0},
    '{3'd2, OP_WCORE, 4'd0, `SCHED_REG_INCOME, 32'h0000_0040, 5'd0, 1'b0, 1'b0},
    '{3'd2, OP_REQ, 4'd1, 4'd6, 32'h1234_5676, 5'd5, 1'b0, 1'b0},
    '{3'd2, OP_DRAIN, 4'd0, 4'd0, 32'h0, 5'd0, 1'b0, 1'b0},
    '{3'd2, OP_REQ, 4'd1, 4'd6, 32'h0BAD_F006, 5'd9, 1'b0, 1'b0},
    '{3'd2, OP_DRAIN, 4'd0, 4'd0, 32'h0, 5'd0, 1'b0, 1'b0},
    '{3'd2, OP_RCORE, 4'd6, `SCHED_REG_SLOTS, 32'h0, 5'd0, 1'b0, 1'b0},
    '{3'd3, OP_LINES, 4'd2, 4'd0, 32'd4000, 5'd0, 1'b0, 1'b0},
    '{3'd3, OP_REQ, 4'd2, 4'd2, 32'h00C0_FFE2, 5'd0, 1'b1, 1'b0},
    '{3'd3, OP_DRAIN, 4'd0, 4'd0, 32'h0, 5'd0, 1'b0, 1'b0},
    '{3'd3, OP_RPORT, 4'd2, `SCHED_REG_DROPS, 32'd1, 5'd0, 1'b0, 1'b0},
    '{3'd4, OP_LINES, 4'd2, 4'd0, 32'd100, 5'd0, 1'b0, 1'b0},
    '{3'd4, OP_REQ, 4'd2, 4'd2, 32'h5555_0002, 5'd7, 1'b0, 1'b0},
    '{3'd4, OP_QUIET, 4'd0, 4'd0, 32'h0, 5'd0, 1'b0, 1'b0},
    '{3'd4, OP_RET, 4'd2, 4'd0, 32'h0, 5'd7, 1'b0, 1'b0},
    '{3'd4, OP_WCORE, 4'd0, `SCHED_REG_INCOME, 32'h0000_0044, 5'd0, 1'b0, 1'b0},
    '{3'd4, OP_DRAIN, 4'd0, 4'd0, 32'h0, 5'd0, 1'b0, 1'b0},
    '{3'd5, OP_RET, 4'd4, 4'd0, 32'h0, 5'd1, 1'b0, 1'b0},
    '{3'd5, OP_RET, 4'd4, 4'd0, 32'h0, 5'd2, 1'b0, 1'b0},
    '{3'd5, OP_RET, 4'd4, 4'd0, 32'h0, 5'd3, 1'b0, 1'b0},
    '{3'd5, OP_WCORE, 4'd0, `SCHED_REG_INCOME, 32'h0000_0054, 5'd0, 1'b0, 1'b0},
    '{3'd5, OP_RCORE, 4'd4, `SCHED_REG_SLOTS, 32'd3, 5'd0, 1'b0, 1'b0},
    '{3'd5, OP_WCORE, 4'd0, `SCHED_REG_FLUSH, 32'h0000_0010, 5'd0, 1'b0, 1'b0},
    '{3'd5, OP_RCORE, 4'd4, `SCHED_REG_SLOTS, 32'd0, 5'd0, 1'b0, 1'b0},
    '{3'd5, OP_LINES, 4'd0, 4'd0, 32'd4000, 5'd0, 1'b0, 1'b0},
    '{3'd5, OP_REQ, 4'd0, 4'd4, 32'h7777_0014, 5'd0, 1'b1, 1'b0},
    '{3'd5, OP_DRAIN, 4'd0, 4'd0, 32'h0, 5'd0, 1'b0, 1'b0},
    '{3'd6, OP_RET, 4'd8, 4'd0, 32'h0, 5'd11, 1'b0, 1'b0},
    '{3'd6, OP_RET, 4'd9, 4'd0, 32'h0, 5'd12, 1'b0, 1'b0},
    '{3'd6, OP_RET, 4'd10, 4'd0, 32'h0, 5'd13, 1'b0, 1'b0},
    '{3'd6, OP_WCORE, 4'd0, `SCHED_REG_INCOME, 32'h0000_0700, 5'd0, 1'b0, 1'b0},
    '{3'd6, OP_LINES, 4'd0, 4'd0, 32'd0, 5'd0, 1'b0, 1'b0},
    '{3'd6, OP_REQ, 4'd0, 4'd8, 32'h1000_0008, 5'd11, 1'b0, 1'b0},
    '{3'd6, OP_REQ, 4'd1, 4'd9, 32'h2000_0009, 5'd12, 1'b0, 1'b0},
    '{3'd6, OP_REQ, 4'd2, 4'd10, 32'h3000_000A, 5'd13, 1'b0, 1'b0},
    '{3'd6, OP_DRAIN, 4'd0, 4'd0, 32'h0, 5'd0, 1'b0, 1'b1}
  };

  string test_names [6] = '{"reset readback", "pool fifo order", "drop when nearly full",
                            "wait then allocate", "flush pool", "three ports with stalls"};

  logic                                       clk;
  logic                                       rst_r;
  hash_req_t [IF_COUNT-1:0]                   hash_req;
  logic [IF_COUNT-1:0]                        hash_valid;
  logic [IF_COUNT-1:0]                        hash_ready;
  logic [IF_COUNT-1:0][`SCHED_LINE_WIDTH-1:0] line_count;
  slot_ret_t                                  slot_ret;
  logic                                       slot_valid;
  logic                                       slot_ready;
  rx_desc_t                                   desc;
  logic                                       desc_valid;
  logic                                       desc_ready;
  host_cmd_u                                  host_cmd;
  logic [31:0]                                host_wr_data;
  logic                                       host_valid;
  logic [31:0]                                host_rd_data;

  rx_desc_t            exp_q [$];
  logic [IF_COUNT-1:0] hash_acc;
  logic                slot_acc;
  logic                stall_on;
  int                  cycles;
  int                  checks;
  int                  errors;
  int                  test_errors;
  int                  rx_count;
  string               cur_name;

  rx_scheduler u_rx_scheduler (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic string desc_text(input rx_desc_t d);
    return $sformatf("drop %0b port %0d core %0d slot %0d hash %h",
                     d.drop, d.port, d.core, d.slot, d.hash);
  endfunction

  task automatic compare_desc(input string name, input rx_desc_t exp, input rx_desc_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("error %s: expected %s, actual %s", name, desc_text(exp), desc_text(act));
    end
  endtask

  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Handshakes and per-port descriptor matching at the clock edge
  always @(posedge clk) begin
    int k;
    hash_acc = hash_valid & hash_ready;
    slot_acc = slot_valid && slot_ready;
    if (!rst_r && desc_valid && desc_ready) begin
      rx_count++;
      k = -1;
      for (int i = 0; i < exp_q.size(); i++) begin
        if (k < 0 && exp_q[i].port == desc.port) begin
          k = i;
        end
      end
      if (k < 0) begin
        errors++;
        test_errors++;
        $display("%s: unexpected descriptor on port %0d", cur_name, desc.port);
      end else begin
        compare_desc(cur_name, exp_q[k], desc);
        exp_q.delete(k);
      end
    end
  end

  task automatic step_cycle();
    @(negedge clk);
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run stopped after %0d cycles in %s", cycles, cur_name);
      $display("test failed");
      $finish;
    end else begin
      hash_valid = hash_valid & ~hash_acc;
      desc_ready = stall_on ? ($urandom % 4 != 0) : 1'b1;
    end
  endtask

  function automatic host_cmd_u make_cmd(input logic wr, input logic to_if,
                                         input logic [3:0] idx, input logic [3:0] regnum);
    host_cmd_u c;
    c = '0;
    if (to_if) begin
      c.port_cmd.wr = wr;
      c.port_cmd.to_if = 1'b1;
      c.port_cmd.sched = 1'b1;
      c.port_cmd.port = idx[`SCHED_PORT_WIDTH-1:0];
      c.port_cmd.regnum = regnum;
    end else begin
      c.core_cmd.wr = wr;
      c.core_cmd.sched = 1'b1;
      c.core_cmd.core = idx;
      c.core_cmd.regnum = regnum;
    end
    return c;
  endfunction

  // Read data and write effect both land two cycles after the command
  task automatic host_access(input host_cmd_u cmd, input logic [31:0] data);
    host_cmd = cmd;
    host_wr_data = data;
    host_valid = 1'b1;
    step_cycle();
    host_valid = 1'b0;
    step_cycle();
  endtask

  task automatic run_step(input step_t s);
    rx_desc_t exp;
    int       seen;
    case (s.op)
      OP_RCORE, OP_RPORT: begin
        host_access(make_cmd(1'b0, s.op == OP_RPORT, s.idx, s.regnum), 32'h0);
        compare_word(cur_name, s.value, host_rd_data);
      end
      OP_WCORE: begin
        host_access(make_cmd(1'b1, 1'b0, s.idx, s.regnum), s.value);
      end
      OP_RET: begin
        slot_ret.core = s.idx;
        slot_ret.slot = s.slot;
        slot_valid = 1'b1;
        step_cycle();
        while (!slot_acc) begin
          step_cycle();
        end
        slot_valid = 1'b0;
      end
      OP_LINES: begin
        // The count is registered and the flag follows one cycle later
        line_count[s.idx[1:0]] = s.value[`SCHED_LINE_WIDTH-1:0];
        repeat (3) step_cycle();
      end
      OP_REQ: begin
        exp.drop = s.drop;
        exp.port = s.idx[1:0];
        exp.core = s.regnum;
        exp.slot = s.drop ? '0 : s.slot;
        exp.hash = s.value;
        exp_q.push_back(exp);
        hash_req[s.idx[1:0]].hash = s.value;
        hash_valid[s.idx[1:0]] = 1'b1;
      end
      OP_QUIET: begin
        seen = rx_count;
        repeat (20) step_cycle();
        checks++;
        if (rx_count != seen) begin
          errors++;
          test_errors++;
          $display("%s: a descriptor appeared while the request should wait", cur_name);
        end
      end
      OP_DRAIN: begin
        stall_on = s.stall;
        while (exp_q.size() != 0) begin
          step_cycle();
        end
        stall_on = 1'b0;
      end
      default: begin
      end
    endcase
  endtask

  initial begin
    int assert_fails;
    void'($urandom(66));
    rst_r = 1'b1;
    hash_req = '0;
    hash_valid = '0;
    line_count = '0;
    slot_ret = '0;
    slot_valid = 1'b0;
    desc_ready = 1'b1;
    host_cmd = '0;
    host_wr_data = '0;
    host_valid = 1'b0;
    hash_acc = '0;
    slot_acc = 1'b0;
    stall_on = 1'b0;
    cycles = 0;
    checks = 0;
    errors = 0;
    test_errors = 0;
    rx_count = 0;
    cur_name = test_names[0];
    repeat (8) step_cycle();
    rst_r = 1'b0;
    for (int i = 0; i < STEP_COUNT; i++) begin
      cur_name = test_names[int'(STEPS[i].test) - 1];
      run_step(STEPS[i]);
      if (i == STEP_COUNT - 1 || STEPS[i + 1].test != STEPS[i].test) begin
        if (test_errors == 0) begin
          $display("%s: ok", cur_name);
        end else begin
          $display("%s: %0d errors", cur_name, test_errors);
        end
        test_errors = 0;
      end
    end
    repeat (4) step_cycle();
    assert_fails = u_rx_scheduler.u_rx_scheduler_assert.assert_errors;
    if (assert_fails != 0) begin
      $display("protocol assertions fired %0d times", assert_fails);
      errors += assert_fails;
    end
    $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+hdl
hdl/sched_pkg.sv
hdl/port_arbiter.sv
hdl/slot_pool.sv
hdl/desc_allocator.sv
hdl/host_regs.sv
hdl/rx_scheduler.sv
sim/rx_scheduler_assert.sv
sim/rx_scheduler_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns -Wno-fatal
TOP       = rx_scheduler_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
